// File: Makefile
# Verilator simulation of the Wishbone subsystem

VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FILELIST  ?= wb_subsys_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^TB PASSED$$" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_wb_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_wb_subsys;
  import wb_ic_pkg::*;

  // Watchdog allows 64 cycles for each of the 34 bus cycles plus the reset
  localparam int TXN_COUNT  = 34;
  localparam int MAX_CYCLES = 64 * TXN_COUNT + 8;

  logic    wb_clk_i;
  logic    wb_rst_i;
  wb_req_t wbm_req;
  wb_rsp_t wbm_rsp;
  int      cycle_cnt;
  int      seed;

  wb_subsys_top UUT (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_req_i (wbm_req),
    .wbm_rsp_o (wbm_rsp)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;
  end

  // Watchdog on the whole run
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge wb_clk_i);
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES) begin
        $display("Run did not finish within %0d cycles", MAX_CYCLES);
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
      end
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %08h, actual %08h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // One classic cycle held until ack or err and then released
  task automatic bus_cycle(input logic we, input logic [31:0] adr,
                           input logic [31:0] wdat, input logic [3:0] sel,
                           output logic ack, output logic err,
                           output logic [31:0] rdat, output int cycles);
    @(posedge wb_clk_i);
    wbm_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
    cycles = 0;
    do begin
      @(posedge wb_clk_i);
      cycles++;
    end while (!(wbm_rsp.ack || wbm_rsp.err));
    ack  = wbm_rsp.ack;
    err  = wbm_rsp.err;
    rdat = wbm_rsp.dat;
    wbm_req <= '0;
    @(posedge wb_clk_i);
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] wdat,
                            input logic [3:0] sel, output logic ack, output logic err);
    logic [31:0] unused_dat;
    int          cycles;
    bus_cycle(1'b1, adr, wdat, sel, ack, err, unused_dat, cycles);
  endtask

  task automatic read_word(input logic [31:0] adr, output logic ack,
                           output logic err, output logic [31:0] rdat);
    int cycles;
    bus_cycle(1'b0, adr, 32'h0, 4'hF, ack, err, rdat, cycles);
  endtask

  task automatic read_id();
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    read_word(32'h0, ack, err, rdat);
    check("read_id ack", 1, ack);
    check("read_id data", REG_ID_VALUE, rdat);
  endtask

  task automatic reg_write_readback();
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    logic [31:0] d1;
    logic [31:0] d2;
    d1 = $random(seed);
    d2 = $random(seed);
    write_word(32'hC, d1, 4'hF, ack, err);
    check("reg_write_readback full write ack", 1, ack);
    read_word(32'hC, ack, err, rdat);
    check("reg_write_readback full word", d1, rdat);
    write_word(32'hC, d2, 4'h2, ack, err);
    check("reg_write_readback byte write ack", 1, ack);
    read_word(32'hC, ack, err, rdat);
    // Select 0x2 replaces byte 1 and keeps the other three bytes
    check("reg_write_readback byte 1 only", {d1[31:16], d2[15:8], d1[7:0]}, rdat);
  endtask

  task automatic mem_write_readback();
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    logic [31:0] addrs [10];
    logic [31:0] vals  [10];
    logic [31:0] r1;
    for (int i = 0; i < 10; i++) begin
      // Stride of 37 words keeps the ten addresses distinct
      addrs[i] = 32'h1000 + 32'((i * 37) % 1024) * 32'd4;
      vals[i]  = $random(seed);
      write_word(addrs[i], vals[i], 4'hF, ack, err);
      check("mem_write_readback write ack", 1, ack);
    end
    for (int i = 0; i < 10; i++) begin
      read_word(addrs[i], ack, err, rdat);
      check("mem_write_readback read ack", 1, ack);
      check("mem_write_readback data", vals[i], rdat);
    end
    // Same offset in two windows must land in two slaves
    r1 = $random(seed);
    write_word(32'h10, r1, 4'hF, ack, err);
    check("mem_write_readback reg 0x10 ack", 1, ack);
    write_word(32'h1010, ~r1, 4'hF, ack, err);
    check("mem_write_readback mem 0x1010 ack", 1, ack);
    read_word(32'h10, ack, err, rdat);
    check("mem_write_readback reg 0x10 data", r1, rdat);
    read_word(32'h1010, ack, err, rdat);
    check("mem_write_readback mem 0x1010 data", ~r1, rdat);
  endtask

  task automatic unmapped_access();
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    read_word(32'h8000, ack, err, rdat);
    check("unmapped_access err", 1, err);
    check("unmapped_access no ack", 0, ack);
    read_word(32'h0, ack, err, rdat);
    check("unmapped_access recovery ack", 1, ack);
    check("unmapped_access recovery data", REG_ID_VALUE, rdat);
  endtask

  task automatic reserved_timeout();
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    int          cycles;
    bus_cycle(1'b0, 32'h2004, 32'h0, 4'hF, ack, err, rdat, cycles);
    check("reserved_timeout err", 1, err);
    check("reserved_timeout no ack", 0, ack);
    check("reserved_timeout latency at least limit", 1, cycles >= TIMEOUT_CYCLES);
  endtask

  task automatic id_write_rejected();
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    write_word(32'h0, 32'hDEAD_BEEF, 4'hF, ack, err);
    check("id_write_rejected err", 1, err);
    check("id_write_rejected no ack", 0, ack);
    read_word(32'h0, ack, err, rdat);
    check("id_write_rejected read ack", 1, ack);
    check("id_write_rejected id unchanged", REG_ID_VALUE, rdat);
  endtask

  initial begin
    seed     = 47;
    wb_rst_i = 1'b1;
    wbm_req  = '0;
    repeat (8) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    @(posedge wb_clk_i);
    read_id();
    reg_write_readback();
    mem_write_readback();
    unmapped_access();
    reserved_timeout();
    id_write_rejected();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: wb_ic_pkg.sv
`default_nettype none

package wb_ic_pkg;

  // Decode slots and their roles in the subsystem
  localparam int N_SLAVES  = 3;
  localparam int SLOT_W    = $clog2(N_SLAVES);
  localparam int SLOT_REG  = 0;
  localparam int SLOT_MEM  = 1;
  localparam int SLOT_RSVD = 2;

  // Address map, inclusive windows, slot 0 in the lowest entry
  localparam logic [N_SLAVES-1:0][31:0] SLAVE_BASE = {
    32'h0000_2000, 32'h0000_1000, 32'h0000_0000
  };
  localparam logic [N_SLAVES-1:0][31:0] SLAVE_HIGH = {
    32'h0000_2FFF, 32'h0000_1FFF, 32'h0000_00FF
  };

  // Slave silence limit and post-completion drain
  localparam int TIMEOUT_CYCLES = 16;
  localparam int TIMEOUT_W      = $clog2(TIMEOUT_CYCLES + 1);
  localparam int HOLD_CYCLES    = 3;

  localparam logic [31:0] REG_ID_VALUE = 32'h5742_4943;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {ARB_IDLE, ARB_WAIT, ARB_HOLD} arb_state_t;

endpackage

`default_nettype wire

// File: wb_mem_slave.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_slave (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               wbs_cyc_i,
  input  wb_ic_pkg::wb_req_t wbs_req_i,
  output wb_ic_pkg::wb_rsp_t wbs_rsp_o
);
  import wb_ic_pkg::*;

  logic [31:0] mem [0:1023];
  logic [9:0]  idx;
  logic        start;
  logic        phase_q;
  logic        busy_q;
  logic        ack_q;
  logic [31:0] dat_q;

  assign idx   = wbs_req_i.adr[11:2];
  assign start = wbs_cyc_i && wbs_req_i.stb && !phase_q && !busy_q;

  // First cycle latches the request, second one acks
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      phase_q <= 1'b0;
      busy_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (!wbs_cyc_i) busy_q <= 1'b0;
      if (start) phase_q <= 1'b1;
      if (phase_q) begin
        phase_q <= 1'b0;
        ack_q   <= wbs_cyc_i;
        busy_q  <= 1'b1;
      end
    end
  end

  // Array access in the wait state, works for synchronous RAM
  always_ff @(posedge wb_clk_i) begin
    if (phase_q) begin
      dat_q <= mem[idx];
      if (wbs_cyc_i && wbs_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (wbs_req_i.sel[b]) mem[idx][8*b +: 8] <= wbs_req_i.dat[8*b +: 8];
        end
      end
    end
  end

  assign wbs_rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};

  a_single_ack: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) ack_q |=> !ack_q
  );

endmodule

`default_nettype wire

// File: wb_reg_slave.sv
`timescale 1ns/100ps
`default_nettype none

module wb_reg_slave (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               wbs_cyc_i,
  input  wb_ic_pkg::wb_req_t wbs_req_i,
  output wb_ic_pkg::wb_rsp_t wbs_rsp_o
);
  import wb_ic_pkg::*;

  logic [31:0] regs_q [1:15];
  logic [5:0]  word;
  logic        in_regs;
  logic        hit;
  logic        busy_q;
  logic        ack_q;
  logic        err_q;
  logic [31:0] dat_q;
  logic [31:0] rd_data;

  // Word offset inside the 256-byte window
  assign word    = wbs_req_i.adr[7:2];
  assign in_regs = (word[5:4] == 2'b00);
  // busy_q keeps one response per cycle until cyc falls
  assign hit     = wbs_cyc_i && wbs_req_i.stb && !busy_q;

  always_comb begin
    rd_data = '0;
    if (word == 6'd0) begin
      rd_data = REG_ID_VALUE;
    end else if (in_regs) begin
      rd_data = regs_q[word[3:0]];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (hit) dat_q <= rd_data;
    if (wb_rst_i) begin
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      busy_q <= 1'b0;
      for (int r = 1; r < 16; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (!wbs_cyc_i) busy_q <= 1'b0;
      if (hit) begin
        busy_q <= 1'b1;
        // ID word is read only
        if (wbs_req_i.we && word == 6'd0) begin
          err_q <= 1'b1;
        end else begin
          ack_q <= 1'b1;
        end
        if (wbs_req_i.we && in_regs && word != 6'd0) begin
          for (int b = 0; b < 4; b++) begin
            if (wbs_req_i.sel[b]) regs_q[word[3:0]][8*b +: 8] <= wbs_req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  assign wbs_rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

`default_nettype wire

// File: wb_subsys_top.f
wb_ic_pkg.sv
wb_timeout.sv
wbs_arbiter.sv
wb_reg_slave.sv
wb_mem_slave.sv
wb_subsys_top.sv
tb_wb_subsys.sv

// File: wb_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module wb_subsys_top (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  wb_ic_pkg::wb_req_t wbm_req_i,
  output wb_ic_pkg::wb_rsp_t wbm_rsp_o
);
  import wb_ic_pkg::*;

  wb_req_t             wbs_req;
  logic [N_SLAVES-1:0] wbs_cyc;
  wb_rsp_t             wbs_rsp [N_SLAVES];

  wbs_arbiter u_arbiter (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_req_i (wbm_req_i),
    .wbm_rsp_o (wbm_rsp_o),
    .wbs_req_o (wbs_req),
    .wbs_cyc_o (wbs_cyc),
    .wbs_rsp_i (wbs_rsp)
  );

  // Control and ID registers
  wb_reg_slave u_reg_slave (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc[SLOT_REG]),
    .wbs_req_i (wbs_req),
    .wbs_rsp_o (wbs_rsp[SLOT_REG])
  );

  // 4 KB data memory
  wb_mem_slave u_mem_slave (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc[SLOT_MEM]),
    .wbs_req_i (wbs_req),
    .wbs_rsp_o (wbs_rsp[SLOT_MEM])
  );

  // Reserved window never answers, the arbiter times it out
  assign wbs_rsp[SLOT_RSVD] = '0;

endmodule

`default_nettype wire

// File: wb_timeout.sv
`timescale 1ns/100ps
`default_nettype none

module wb_timeout (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic count_en_i,
  output logic expired_o
);
  import wb_ic_pkg::*;

  logic [TIMEOUT_W-1:0] count_q;

  // Saturates at the limit so the flag stays up until the enable drops
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !count_en_i) begin
      count_q <= '0;
    end else if (count_q != TIMEOUT_W'(TIMEOUT_CYCLES)) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign expired_o = (count_q == TIMEOUT_W'(TIMEOUT_CYCLES));

  // A fresh expiry needs at least one enabled cycle before it
  a_no_expiry_when_idle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(expired_o) |-> $past(count_en_i)
  );

endmodule

`default_nettype wire

// File: wbs_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wbs_arbiter (
  input  logic                              wb_clk_i,
  input  logic                              wb_rst_i,
  input  wb_ic_pkg::wb_req_t                wbm_req_i,
  output wb_ic_pkg::wb_rsp_t                wbm_rsp_o,
  output wb_ic_pkg::wb_req_t                wbs_req_o,
  output logic [wb_ic_pkg::N_SLAVES-1:0]    wbs_cyc_o,
  input  wb_ic_pkg::wb_rsp_t                wbs_rsp_i [wb_ic_pkg::N_SLAVES]
);
  import wb_ic_pkg::*;

  wb_req_t             req1_q;
  wb_req_t             req2_q;
  wb_req_t             req3_q;
  logic [N_SLAVES-1:0] hit_d;
  logic [N_SLAVES-1:0] hit_q;
  logic [SLOT_W-1:0]   slot_enc;
  logic [SLOT_W-1:0]   slot_q;
  logic                match_q;
  logic [31:0]         base_q;
  wb_rsp_t             rsp_r1_q [N_SLAVES];
  wb_rsp_t             rsp_r2_q [N_SLAVES];
  wb_rsp_t             sel_rsp;
  wb_rsp_t             rsp_next;
  arb_state_t          state_q;
  logic [SLOT_W-1:0]   active_q;
  logic [1:0]          hold_cnt_q;
  logic                valid3;
  logic                dispatch;
  logic                wait_done;
  logic                timed_out;

  // Input register, strobes cleared on reset
  always_ff @(posedge wb_clk_i) begin
    req1_q <= wbm_req_i;
    if (wb_rst_i) begin
      req1_q.cyc <= 1'b0;
      req1_q.stb <= 1'b0;
    end
  end

  // Window compare, all slots in parallel
  always_comb begin
    for (int i = 0; i < N_SLAVES; i++) begin
      hit_d[i] = (req1_q.adr >= SLAVE_BASE[i]) && (req1_q.adr <= SLAVE_HIGH[i]);
    end
  end

  // Strobes entering while busy are dropped here
  always_ff @(posedge wb_clk_i) begin
    hit_q      <= hit_d;
    req2_q     <= req1_q;
    req2_q.cyc <= req1_q.cyc && (state_q == ARB_IDLE);
    req2_q.stb <= req1_q.stb && (state_q == ARB_IDLE);
    if (wb_rst_i) begin
      req2_q.cyc <= 1'b0;
      req2_q.stb <= 1'b0;
    end
  end

  always_comb begin
    slot_enc = '0;
    for (int i = 0; i < N_SLAVES; i++) begin
      if (hit_q[i]) slot_enc = SLOT_W'(i);
    end
  end

  // Slot encode and base lookup
  always_ff @(posedge wb_clk_i) begin
    slot_q  <= slot_enc;
    match_q <= |hit_q;
    base_q  <= SLAVE_BASE[slot_enc];
    req3_q  <= req2_q;
    if (wb_rst_i) begin
      req3_q.cyc <= 1'b0;
      req3_q.stb <= 1'b0;
    end
  end

  assign valid3   = req3_q.cyc && req3_q.stb;
  assign dispatch = (state_q == ARB_IDLE) && valid3 && match_q;

  // Two response alignment stages
  always_ff @(posedge wb_clk_i) begin
    for (int i = 0; i < N_SLAVES; i++) begin
      rsp_r1_q[i] <= wbs_rsp_i[i];
      rsp_r2_q[i] <= rsp_r1_q[i];
      if (wb_rst_i) begin
        rsp_r1_q[i].ack <= 1'b0;
        rsp_r1_q[i].err <= 1'b0;
        rsp_r2_q[i].ack <= 1'b0;
        rsp_r2_q[i].err <= 1'b0;
      end
    end
  end

  wb_timeout u_timeout (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .count_en_i (state_q == ARB_WAIT),
    .expired_o  (timed_out)
  );

  // Only the active slot is looked at
  assign sel_rsp   = rsp_r2_q[active_q];
  assign wait_done = (state_q == ARB_WAIT) && (sel_rsp.ack || sel_rsp.err || timed_out);

  always_comb begin
    rsp_next     = '0;
    rsp_next.dat = sel_rsp.dat;
    case (state_q)
      ARB_IDLE: rsp_next.err = valid3 && !match_q;
      ARB_WAIT: begin
        rsp_next.ack = sel_rsp.ack;
        rsp_next.err = !sel_rsp.ack && (sel_rsp.err || timed_out);
      end
      default: ;
    endcase
  end

  // Dispatch register and FSM
  always_ff @(posedge wb_clk_i) begin
    if (dispatch) begin
      wbs_req_o.we  <= req3_q.we;
      wbs_req_o.sel <= req3_q.sel;
      wbs_req_o.adr <= req3_q.adr - base_q;
      wbs_req_o.dat <= req3_q.dat;
    end
    if (wb_rst_i) begin
      state_q       <= ARB_IDLE;
      active_q      <= '0;
      hold_cnt_q    <= '0;
      wbs_cyc_o     <= '0;
      wbs_req_o.cyc <= 1'b0;
      wbs_req_o.stb <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (dispatch) begin
            wbs_cyc_o     <= {{(N_SLAVES-1){1'b0}}, 1'b1} << slot_q;
            wbs_req_o.cyc <= 1'b1;
            wbs_req_o.stb <= 1'b1;
            active_q      <= slot_q;
            state_q       <= ARB_WAIT;
          end else if (valid3) begin
            // Decode miss, err goes out with the output register
            hold_cnt_q <= '0;
            state_q    <= ARB_HOLD;
          end
        end
        ARB_WAIT: begin
          if (wait_done) begin
            wbs_cyc_o     <= '0;
            wbs_req_o.cyc <= 1'b0;
            wbs_req_o.stb <= 1'b0;
            hold_cnt_q    <= '0;
            state_q       <= ARB_HOLD;
          end
        end
        ARB_HOLD: begin
          if (hold_cnt_q == 2'(HOLD_CYCLES - 1)) begin
            state_q <= ARB_IDLE;
          end else begin
            hold_cnt_q <= hold_cnt_q + 1'b1;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Output register
  always_ff @(posedge wb_clk_i) begin
    wbm_rsp_o.dat <= rsp_next.dat;
    if (wb_rst_i) begin
      wbm_rsp_o.ack <= 1'b0;
      wbm_rsp_o.err <= 1'b0;
    end else begin
      wbm_rsp_o.ack <= rsp_next.ack;
      wbm_rsp_o.err <= rsp_next.err;
    end
  end

  a_cyc_onehot0: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) $onehot0(wbs_cyc_o)
  );

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(wbm_rsp_o.ack && wbm_rsp_o.err)
  );

endmodule

`default_nettype wire
